// ==== flist.f ====
src/trace_pkg.sv
src/capture_pkg.sv
src/trace_sampler.sv
src/pattern_matcher.sv
src/pulse_trigger.sv
src/capture_ctrl.sv
src/capture_fifo.sv
src/trace_capture_top.sv
test/trace_capture_tb.sv

// ==== test/trace_capture_tb.sv ====
// trace capture engine testbench
// random trace stimulus checked every cycle against a cycle model
`timescale 1ns/1ps

module trace_capture_tb
   import trace_pkg::*, capture_pkg::*;
();

   localparam int NUM_RULES    = 4;
   localparam int BUFFER_BYTES = 4;
   localparam int FIFO_DEPTH   = 64;
   localparam int BUF_W        = BUFFER_BYTES * TRACE_BYTE_W;
   localparam int HIT_MAX      = (1 << HIT_COUNT_W) - 1;
   localparam int STAMP_MAX    = (1 << STAMP_W) - 1;
   localparam int SEED         = 26203;

   localparam int ROUNDS      = 6;
   localparam int ROUND_LEN   = 120;
   localparam int GAP_LEN     = 20 + 300 + 20;
   localparam int SAT_LEN     = 600 + 20;
   localparam int FILL_LEN    = 2 * FIFO_DEPTH + 40;
   localparam int DRAIN_LEN   = FIFO_DEPTH + 20;
   localparam int TOTAL_LEN   = 2 + ROUNDS * (ROUND_LEN + 1) + GAP_LEN + 1 + SAT_LEN + 1
                                + FILL_LEN + 1 + DRAIN_LEN;
   localparam int CYCLE_LIMIT = TOTAL_LEN + 200;

   logic                            trace_clk;
   logic                            reset;
   logic                            trcena;
   logic [TRACE_PORT_W-1:0]         trace_data;
   logic                            arm;
   logic [LEN_W-1:0]                capture_len;
   logic [NUM_RULES-1:0]            rule_enable;
   logic [NUM_RULES-1:0]            rule_trig_enable;
   logic [NUM_RULES-1:0][BUF_W-1:0] rule_pattern;
   logic [NUM_RULES-1:0][BUF_W-1:0] rule_mask;
   logic [DELAY_W-1:0]              trigger_delay;
   logic [PULSE_W-1:0]              trigger_width;
   logic                            fifo_rd;
   logic [RECORD_W-1:0]             fifo_rdata;
   logic                            fifo_empty;
   logic                            capturing;
   logic                            capture_done;
   logic                            overflow;
   logic                            trig_out;
   logic [NUM_RULES-1:0]            rule_match;
   logic [NUM_RULES-1:0][HIT_COUNT_W-1:0] hit_count;

   // reference model state
   logic                    m_phase;
   logic [TRACE_PORT_W-1:0] m_lo;
   logic [TRACE_BYTE_W-1:0] m_byte;
   logic                    m_bvalid;
   logic [BUF_W-1:0]        m_buf;     // newest byte in lane 0
   int                      m_fill;
   logic [NUM_RULES-1:0]    m_match;
   int                      m_hits [NUM_RULES];
   logic                    m_ready;
   int                      win_start;   // trigger pulse window, in cycles
   int                      win_end;
   logic                    m_capturing;
   logic                    m_done;
   logic                    m_ovf;
   int                      m_count;
   logic                    m_first;
   int                      last_wr;
   logic [RECORD_W-1:0]     exp_q [$];   // expected FIFO contents

   int cyc         = 0;
   int cycle_count = 0;
   int pops        = 0;
   int n_checks    = 0;
   int n_errors    = 0;

   trace_capture_top #(
      .NUM_RULES    (NUM_RULES),
      .BUFFER_BYTES (BUFFER_BYTES),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) u_dut (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .trcena           (trcena),
      .trace_data       (trace_data),
      .arm              (arm),
      .capture_len      (capture_len),
      .rule_enable      (rule_enable),
      .rule_trig_enable (rule_trig_enable),
      .rule_pattern     (rule_pattern),
      .rule_mask        (rule_mask),
      .trigger_delay    (trigger_delay),
      .trigger_width    (trigger_width),
      .fifo_rd          (fifo_rd),
      .fifo_rdata       (fifo_rdata),
      .fifo_empty       (fifo_empty),
      .capturing        (capturing),
      .capture_done     (capture_done),
      .overflow         (overflow),
      .trig_out         (trig_out),
      .rule_match       (rule_match),
      .hit_count        (hit_count)
   );

   initial trace_clk = 1'b0;
   always #2 trace_clk = ~trace_clk;   // 4 ns period

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // small alphabet so that masked rules hit often
   function automatic logic [TRACE_PORT_W-1:0] pick_nibble();
      case ($urandom % 4)
         0:       return 4'h6;
         1:       return 4'h9;
         2:       return 4'h3;
         default: return 4'hC;
      endcase
   endfunction

   task automatic run_cycles(input int n, input int ena_pct, input int rd_pct);
      repeat (n) begin
         @(posedge trace_clk);
         arm        <= 1'b0;
         trcena     <= (($urandom % 100) < ena_pct);
         trace_data <= pick_nibble();
         fifo_rd    <= (($urandom % 100) < rd_pct);
      end
   endtask

   // new rules and settings, applied in the arm cycle
   task automatic start_capture(input int len, input int delay, input int width,
                                input bit always_rule);
      logic [NUM_RULES-1:0][BUF_W-1:0] pat;
      logic [NUM_RULES-1:0][BUF_W-1:0] msk;
      @(posedge trace_clk);
      for (int r = 0; r < NUM_RULES; r++) begin
         for (int b = 0; b < BUFFER_BYTES; b++)
            pat[r][b*TRACE_BYTE_W +: TRACE_BYTE_W] = {pick_nibble(), pick_nibble()};
         msk[r] = BUF_W'($urandom & $urandom & $urandom);   // about 4 bits compared
      end
      if (always_rule)
         msk[NUM_RULES-1] = '0;
      rule_pattern     <= pat;
      rule_mask        <= msk;
      rule_enable      <= always_rule ? {NUM_RULES{1'b1}} : NUM_RULES'($urandom);
      rule_trig_enable <= NUM_RULES'(1 + $urandom % 15);
      capture_len      <= LEN_W'(len);
      trigger_delay    <= DELAY_W'(delay);
      trigger_width    <= PULSE_W'(width);
      arm              <= 1'b1;
      trcena           <= 1'b0;
      fifo_rd          <= 1'b0;
   endtask

   task automatic check_hits();
      @(negedge trace_clk);
      for (int r = 0; r < NUM_RULES; r++)
         compare_value($sformatf("hit_count[%0d]", r), hit_count[r], m_hits[r]);
   endtask

   // cycle model, later pipeline stages first so they see last cycle's values
   always @(posedge trace_clk) begin : ref_model
      logic                 was_full;
      logic [STAMP_W-1:0]   stamp;
      logic [NUM_RULES-1:0] hit;
      if (reset) begin
         m_phase     = 1'b0;
         m_bvalid    = 1'b0;
         m_fill      = 0;
         m_match     = '0;
         m_ready     = 1'b0;
         win_start   = 0;
         win_end     = 0;
         m_capturing = 1'b0;
         m_done      = 1'b0;
         m_ovf       = 1'b0;
         m_count     = 0;
         m_first     = 1'b1;
         exp_q.delete();
         foreach (m_hits[r])
            m_hits[r] = 0;
      end else begin
         was_full = (exp_q.size() == FIFO_DEPTH);
         if (fifo_rd && exp_q.size() != 0)
            void'(exp_q.pop_front());
         m_done = 1'b0;
         if (m_capturing && m_bvalid) begin
            if (was_full) begin
               m_ovf       = 1'b1;   // byte lost
               m_capturing = 1'b0;
               m_done      = 1'b1;
            end else begin
               if (m_first)
                  stamp = '0;
               else if (cyc - last_wr > STAMP_MAX)
                  stamp = '1;
               else
                  stamp = STAMP_W'(cyc - last_wr);
               exp_q.push_back({stamp, m_byte});
               m_first = 1'b0;
               last_wr = cyc;
               m_count++;
               if (capture_len != 0 && m_count == capture_len) begin
                  m_capturing = 1'b0;
                  m_done      = 1'b1;
               end
            end
         end
         // a byte in the arm cycle still goes to the old capture
         if (arm) begin
            m_capturing = 1'b1;
            m_ovf       = 1'b0;
            m_count     = 0;
            m_first     = 1'b1;
            m_done      = 1'b0;
         end
         hit = m_match & rule_trig_enable;
         if (arm) begin
            m_ready   = 1'b1;
            win_start = 0;
            win_end   = 0;
         end else if (m_ready && hit != '0) begin
            m_ready   = 1'b0;
            win_start = cyc + int'(trigger_delay) + 1;
            win_end   = win_start + int'(trigger_width);
         end
         for (int r = 0; r < NUM_RULES; r++) begin
            if (arm)
               m_hits[r] = 0;
            else if (m_match[r] && m_hits[r] < HIT_MAX)
               m_hits[r]++;
         end
         m_match = '0;
         if (m_bvalid) begin
            m_buf = {m_buf[BUF_W-TRACE_BYTE_W-1:0], m_byte};
            if (m_fill < BUFFER_BYTES)
               m_fill++;
            for (int r = 0; r < NUM_RULES; r++)
               m_match[r] = rule_enable[r] && m_fill >= BUFFER_BYTES &&
                            (((m_buf ^ rule_pattern[r]) & rule_mask[r]) == '0);
         end
         m_bvalid = trcena && m_phase;
         if (trcena && m_phase)
            m_byte = {trace_data, m_lo};   // second nibble is the high half
         if (trcena && !m_phase)
            m_lo = trace_data;
         m_phase = trcena && !m_phase;
      end
      cyc++;
   end

   always @(negedge trace_clk) begin
      if (!reset) begin
         compare_value("rule_match", rule_match, m_match);
         compare_value("trig_out", trig_out, cyc >= win_start && cyc < win_end);
         compare_value("capturing", capturing, m_capturing);
         compare_value("capture_done", capture_done, m_done);
         compare_value("overflow", overflow, m_ovf);
         compare_value("fifo_empty", fifo_empty, exp_q.size() == 0);
         if (exp_q.size() != 0)
            compare_value("fifo_rdata", fifo_rdata, exp_q[0]);
         if (fifo_rd && !fifo_empty)
            pops++;
      end
   end

   always @(posedge trace_clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      void'($urandom(SEED));
      reset            = 1'b1;
      trcena           = 1'b0;
      trace_data       = '0;
      arm              = 1'b0;
      capture_len      = '0;
      rule_enable      = '0;
      rule_trig_enable = '0;
      rule_pattern     = '0;
      rule_mask        = '0;
      trigger_delay    = '0;
      trigger_width    = '0;
      fifo_rd          = 1'b0;
      repeat (2) @(posedge trace_clk);
      reset <= 1'b0;

      // random rounds, each one re-arms the trigger
      for (int i = 0; i < ROUNDS; i++) begin
         start_capture(1 + $urandom % 20, $urandom % 21, $urandom % 11, 1'b0);
         run_cycles(ROUND_LEN, 80, 50);
         check_hits();
      end

      // long idle gap saturates the stamp
      start_capture(0, 5, 3, 1'b0);
      run_cycles(20, 100, 100);
      run_cycles(300, 0, 100);
      run_cycles(20, 100, 100);
      check_hits();

      // always-matching rule saturates its counter
      start_capture(0, 0, 1, 1'b1);
      run_cycles(600, 100, 100);
      run_cycles(20, 0, 100);
      check_hits();
      compare_value("hit_count[3]", hit_count[NUM_RULES-1], HIT_MAX);

      // no reads until overflow, then drain
      start_capture(0, 0, 0, 1'b0);
      pops = 0;
      run_cycles(FILL_LEN, 100, 0);
      run_cycles(DRAIN_LEN, 0, 100);
      @(negedge trace_clk);
      compare_value("overflow", overflow, 1'b1);
      compare_value("records drained", pops, FIFO_DEPTH);
      compare_value("fifo_empty", fifo_empty, 1'b1);

      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// ==== src/trace_capture_top.sv ====
// trace capture engine top
// sampler, pattern matcher, trigger, capture control and record FIFO
`timescale 1ns/1ps

module trace_capture_top
   import trace_pkg::*;
   import capture_pkg::*;
#(
   parameter int NUM_RULES    = 4,
   parameter int BUFFER_BYTES = 4,
   parameter int FIFO_DEPTH   = 64
) (
   input  logic                                                trace_clk,
   input  logic                                                reset,
   input  logic                                                trcena,
   input  logic [TRACE_PORT_W-1:0]                             trace_data,
   input  logic                                                arm,
   input  logic [LEN_W-1:0]                                    capture_len,
   input  logic [NUM_RULES-1:0]                                rule_enable,
   input  logic [NUM_RULES-1:0]                                rule_trig_enable,
   input  logic [NUM_RULES-1:0][BUFFER_BYTES*TRACE_BYTE_W-1:0] rule_pattern,
   input  logic [NUM_RULES-1:0][BUFFER_BYTES*TRACE_BYTE_W-1:0] rule_mask,
   input  logic [DELAY_W-1:0]                                  trigger_delay,
   input  logic [PULSE_W-1:0]                                  trigger_width,
   input  logic                                                fifo_rd,
   output logic [RECORD_W-1:0]                                 fifo_rdata,
   output logic                                                fifo_empty,
   output logic                                                capturing,
   output logic                                                capture_done,
   output logic                                                overflow,
   output logic                                                trig_out,
   output logic [NUM_RULES-1:0]                                rule_match,
   output logic [NUM_RULES-1:0][HIT_COUNT_W-1:0]               hit_count
);

   logic [TRACE_BYTE_W-1:0] trace_byte;
   logic                    byte_valid;
   logic [RECORD_W-1:0]     rec_data;
   logic                    rec_wr;
   logic                    fifo_full;

   trace_sampler u_sampler (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .trcena     (trcena),
      .trace_data (trace_data),
      .trace_byte (trace_byte),
      .byte_valid (byte_valid)
   );

   pattern_matcher #(
      .NUM_RULES    (NUM_RULES),
      .BUFFER_BYTES (BUFFER_BYTES)
   ) u_matcher (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .trace_byte   (trace_byte),
      .byte_valid   (byte_valid),
      .rule_enable  (rule_enable),
      .rule_pattern (rule_pattern),
      .rule_mask    (rule_mask),
      .rule_match   (rule_match),
      .hit_count    (hit_count)
   );

   pulse_trigger #(
      .NUM_RULES (NUM_RULES)
   ) u_trigger (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .arm              (arm),
      .rule_match       (rule_match),
      .rule_trig_enable (rule_trig_enable),
      .trigger_delay    (trigger_delay),
      .trigger_width    (trigger_width),
      .trig_out         (trig_out)
   );

   capture_ctrl u_capture (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .trace_byte   (trace_byte),
      .byte_valid   (byte_valid),
      .capture_len  (capture_len),
      .fifo_full    (fifo_full),
      .rec_data     (rec_data),
      .rec_wr       (rec_wr),
      .capturing    (capturing),
      .capture_done (capture_done),
      .overflow     (overflow)
   );

   capture_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .rec_data   (rec_data),
      .rec_wr     (rec_wr),
      .fifo_rd    (fifo_rd),
      .fifo_rdata (fifo_rdata),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full)
   );

endmodule

// ==== src/capture_fifo.sv ====
// record FIFO
// single clock, show-ahead read of the oldest record
`timescale 1ns/1ps

module capture_fifo
   import capture_pkg::*;
#(
   parameter int FIFO_DEPTH = 64
) (
   input  logic                trace_clk,
   input  logic                reset,
   input  logic [RECORD_W-1:0] rec_data,
   input  logic                rec_wr,
   input  logic                fifo_rd,
   output logic [RECORD_W-1:0] fifo_rdata,
   output logic                fifo_empty,
   output logic                fifo_full
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [RECORD_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W:0]      count;   // one extra bit for the full case
   logic                wr_en;
   logic                rd_en;

   assign wr_en      = rec_wr && !fifo_full;
   assign rd_en      = fifo_rd && !fifo_empty;   // read of empty FIFO ignored
   assign fifo_empty = (count == '0);
   assign fifo_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign fifo_rdata = mem[rd_ptr];

   always_ff @(posedge trace_clk) begin
      if (wr_en)
         mem[wr_ptr] <= rec_data;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== src/capture_ctrl.sv ====
// capture controller
// writes timestamped trace records until the length limit or FIFO overflow
`timescale 1ns/1ps

module capture_ctrl
   import trace_pkg::*;
   import capture_pkg::*;
(
   input  logic                    trace_clk,
   input  logic                    reset,
   input  logic                    arm,
   input  logic [TRACE_BYTE_W-1:0] trace_byte,
   input  logic                    byte_valid,
   input  logic [LEN_W-1:0]        capture_len,
   input  logic                    fifo_full,
   output logic [RECORD_W-1:0]     rec_data,
   output logic                    rec_wr,
   output logic                    capturing,
   output logic                    capture_done,
   output logic                    overflow
);

   logic [STAMP_W-1:0] stamp_cnt;   // cycles since last record
   logic               stamp_run;   // held at 0 until the first record
   logic [LEN_W-1:0]   rec_cnt;
   logic [LEN_W-1:0]   rec_cnt_next;
   logic               last_rec;
   logic               drop;

   assign rec_wr       = capturing && byte_valid && !fifo_full;
   assign drop         = capturing && byte_valid && fifo_full;
   assign rec_data     = {stamp_cnt, trace_byte};
   assign rec_cnt_next = rec_cnt + 1'b1;
   assign last_rec     = rec_wr && capture_len != '0 && rec_cnt_next == capture_len;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         capture_done <= 1'b0;
         overflow     <= 1'b0;
         rec_cnt      <= '0;
         stamp_cnt    <= '0;
         stamp_run    <= 1'b0;
      end else begin
         capture_done <= 1'b0;
         if (arm) begin
            capturing <= 1'b1;
            overflow  <= 1'b0;
            rec_cnt   <= '0;
            stamp_cnt <= '0;
            stamp_run <= 1'b0;
         end else begin
            if (rec_wr) begin
               rec_cnt   <= rec_cnt_next;
               stamp_cnt <= STAMP_W'(1);   // next cycle is one after this record
               stamp_run <= 1'b1;
            end else if (stamp_run && stamp_cnt != {STAMP_W{1'b1}}) begin
               stamp_cnt <= stamp_cnt + 1'b1;
            end
            if (last_rec || drop) begin
               capturing    <= 1'b0;
               capture_done <= 1'b1;
            end
            if (drop)
               overflow <= 1'b1;   // sticky until next arm
         end
      end
   end

endmodule

// ==== src/pulse_trigger.sv ====
// single pulse trigger
// fires one delayed pulse on the first enabled rule match after arm
`timescale 1ns/1ps

module pulse_trigger
   import capture_pkg::*;
#(
   parameter int NUM_RULES = 4
) (
   input  logic                 trace_clk,
   input  logic                 reset,
   input  logic                 arm,
   input  logic [NUM_RULES-1:0] rule_match,
   input  logic [NUM_RULES-1:0] rule_trig_enable,
   input  logic [DELAY_W-1:0]   trigger_delay,
   input  logic [PULSE_W-1:0]   trigger_width,
   output logic                 trig_out
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_READY = 2'd1;
   localparam logic [1:0] ST_DELAY = 2'd2;
   localparam logic [1:0] ST_PULSE = 2'd3;

   logic [1:0]         state;
   logic [DELAY_W-1:0] cnt;   // delay, then remaining pulse cycles
   logic               trig_hit;
   logic               start_pulse;

   assign trig_hit    = |(rule_match & rule_trig_enable);
   assign start_pulse = (state == ST_READY && trig_hit && trigger_delay == '0) ||
                        (state == ST_DELAY && cnt == '0);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state    <= ST_IDLE;
         cnt      <= '0;
         trig_out <= 1'b0;
      end else if (arm) begin
         state    <= ST_READY;   // any pulse in flight is dropped
         trig_out <= 1'b0;
      end else if (start_pulse) begin
         if (trigger_width == '0) begin
            state <= ST_IDLE;
         end else begin
            state    <= ST_PULSE;
            trig_out <= 1'b1;
            cnt      <= DELAY_W'(trigger_width - 1'b1);
         end
      end else begin
         case (state)
            ST_READY: begin
               if (trig_hit) begin
                  state <= ST_DELAY;
                  cnt   <= trigger_delay - 1'b1;
               end
            end
            ST_DELAY: cnt <= cnt - 1'b1;
            ST_PULSE: begin
               if (cnt == '0) begin
                  state    <= ST_IDLE;   // stays off until next arm
                  trig_out <= 1'b0;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== src/pattern_matcher.sv ====
// trace pattern matcher
// masked compare of all rules against the last bytes, with hit counters
`timescale 1ns/1ps

module pattern_matcher
   import trace_pkg::*;
#(
   parameter int NUM_RULES    = 4,
   parameter int BUFFER_BYTES = 4
) (
   input  logic                                              trace_clk,
   input  logic                                              reset,
   input  logic                                              arm,
   input  logic [TRACE_BYTE_W-1:0]                           trace_byte,
   input  logic                                              byte_valid,
   input  logic [NUM_RULES-1:0]                              rule_enable,
   input  logic [NUM_RULES-1:0][BUFFER_BYTES*TRACE_BYTE_W-1:0] rule_pattern,
   input  logic [NUM_RULES-1:0][BUFFER_BYTES*TRACE_BYTE_W-1:0] rule_mask,
   output logic [NUM_RULES-1:0]                              rule_match,
   output logic [NUM_RULES-1:0][HIT_COUNT_W-1:0]             hit_count
);

   localparam int BUF_W  = BUFFER_BYTES * TRACE_BYTE_W;
   localparam int FILL_W = $clog2(BUFFER_BYTES + 1);

   logic [BUF_W-1:0]     byte_buf;     // newest byte in lane 0
   logic [BUF_W-1:0]     buf_next;
   logic [FILL_W-1:0]    fill_cnt;
   logic                 buf_ready;
   logic [NUM_RULES-1:0] match_next;

   assign buf_next  = (byte_buf << TRACE_BYTE_W) | BUF_W'(trace_byte);
   assign buf_ready = (fill_cnt >= FILL_W'(BUFFER_BYTES - 1));   // counts the byte coming in

   // all rules compared in parallel against the shifted buffer
   always_comb begin
      for (int r = 0; r < NUM_RULES; r++)
         match_next[r] = rule_enable[r] && buf_ready &&
                         (((buf_next ^ rule_pattern[r]) & rule_mask[r]) == '0);
   end

   always_ff @(posedge trace_clk) begin
      if (byte_valid)
         byte_buf <= buf_next;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         fill_cnt   <= '0;
         rule_match <= '0;
      end else begin
         rule_match <= byte_valid ? match_next : '0;
         if (byte_valid && fill_cnt != FILL_W'(BUFFER_BYTES))
            fill_cnt <= fill_cnt + 1'b1;
      end
   end

   // saturating hit counters, cleared by arm
   always_ff @(posedge trace_clk) begin
      if (reset || arm) begin
         hit_count <= '0;
      end else begin
         for (int r = 0; r < NUM_RULES; r++) begin
            if (rule_match[r] && hit_count[r] != {HIT_COUNT_W{1'b1}})
               hit_count[r] <= hit_count[r] + 1'b1;
         end
      end
   end

endmodule

// ==== src/trace_sampler.sv ====
// trace port sampler
// pairs 4-bit trace nibbles into bytes, low nibble first
`timescale 1ns/1ps

module trace_sampler
   import trace_pkg::*;
(
   input  logic                    trace_clk,
   input  logic                    reset,
   input  logic                    trcena,
   input  logic [TRACE_PORT_W-1:0] trace_data,
   output logic [TRACE_BYTE_W-1:0] trace_byte,
   output logic                    byte_valid
);

   logic                    hi_phase;   // next nibble is the high half
   logic [TRACE_PORT_W-1:0] lo_nibble;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         hi_phase   <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= trcena && hi_phase;   // second nibble seen
         if (!trcena)
            hi_phase <= 1'b0;   // lone low nibble is lost
         else
            hi_phase <= !hi_phase;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (trcena && !hi_phase)
         lo_nibble <= trace_data;
      if (trcena && hi_phase)
         trace_byte <= {trace_data, lo_nibble};
   end

endmodule

// ==== src/capture_pkg.sv ====
// capture record package
// record layout and widths of the trigger and capture settings

package capture_pkg;

   import trace_pkg::*;

   // record is {stamp, byte}, stamp in the high half
   localparam int STAMP_W  = 8;
   localparam int RECORD_W = STAMP_W + TRACE_BYTE_W;

   // trigger settings
   localparam int DELAY_W = 16;
   localparam int PULSE_W = 8;

   // capture length, 0 means unlimited
   localparam int LEN_W = 12;

endpackage

// ==== src/trace_pkg.sv ====
// trace stream package
// widths of the trace port, assembled bytes and rule hit counters

package trace_pkg;

   // parallel trace pins, fixed at 4
   localparam int TRACE_PORT_W = 4;

   // one byte is two nibbles
   localparam int TRACE_BYTE_W = 8;

   // per-rule hit counter, saturates at all ones
   localparam int HIT_COUNT_W = 8;

endpackage
